// File: include/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Load/store unit sizing

// Data bus and address width in bits
`define LSU_DATA_W 32

// One enable per byte lane
`define LSU_BE_W 4

// Max bus transfers in flight, both halves of a split fit
`define LSU_DEPTH 2

// Outstanding counter width, must hold LSU_DEPTH
`define LSU_CNT_W 2

`endif

// File: logic/lsu_pkg.sv
`include "lsu_config.svh"

package lsu_pkg;

  ////////////////////
  // Access size
  ////////////////////

  // Encoding matches funct3[1:0] of RISC-V loads and stores
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  ////////////////////
  // Datapath types
  ////////////////////

  typedef logic [`LSU_DATA_W-1:0]      lsu_word_t;    // Address or data word
  typedef logic [`LSU_BE_W-1:0]        lsu_be_t;      // One bit per byte lane
  typedef logic [$clog2(`LSU_BE_W)-1:0] lsu_offset_t; // Byte within word
  typedef logic [`LSU_CNT_W-1:0]       lsu_cnt_t;     // Outstanding transfers

endpackage

// File: logic/lsu_req_align.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_req_align (
  input  lsu_pkg::lsu_word_t   operand_a_i,
  input  lsu_pkg::lsu_word_t   operand_b_i,
  input  lsu_pkg::lsu_word_t   wdata_i,
  input  lsu_pkg::lsu_size_e   size_i,
  input  logic                 we_i,
  input  logic                 split_q_i,      // Second phase of a split in progress
  output lsu_pkg::lsu_word_t   data_addr_o,
  output lsu_pkg::lsu_word_t   data_wdata_o,
  output lsu_pkg::lsu_be_t     data_be_o,
  output logic                 data_we_o,
  output logic                 split_needed_o, // Access spills into the next word
  output logic                 misaligned_o,   // Not naturally aligned
  output lsu_pkg::lsu_offset_t offset_o
);

  lsu_pkg::lsu_word_t      addr;     // Effective address from operands
  lsu_pkg::lsu_be_t        be_base;  // Enables as if the access were word aligned
  logic [2*`LSU_BE_W-1:0]  be_mask;  // Enables over a two word window
  lsu_pkg::lsu_be_t        be_first;
  lsu_pkg::lsu_be_t        be_second;

  assign addr     = operand_a_i + operand_b_i;
  assign offset_o = addr[1:0];

  // Second phase goes to the following word, starting at lane 0
  assign data_addr_o = split_q_i ? ({addr[`LSU_DATA_W-1:2], 2'b00} +
                                    lsu_pkg::lsu_word_t'(`LSU_BE_W))
                                 : addr;
  assign data_we_o   = we_i;

  ////////////////////
  // Byte enables
  ////////////////////

  always_comb begin
    case (size_i)
      lsu_pkg::SIZE_BYTE: be_base = 4'b0001;
      lsu_pkg::SIZE_HALF: be_base = 4'b0011;
      lsu_pkg::SIZE_WORD: be_base = 4'b1111;
      default:            be_base = 4'b0000; // Reserved size, nothing enabled
    endcase
  end

  // Shift by byte offset, upper half is what lands in the next word
  assign be_mask   = {{`LSU_BE_W{1'b0}}, be_base} << addr[1:0];
  assign be_first  = be_mask[`LSU_BE_W-1:0];
  assign be_second = be_mask[2*`LSU_BE_W-1:`LSU_BE_W];
  assign data_be_o = split_q_i ? be_second : be_first;

  // Split if any lane spills over, but only before phase two is issued
  assign split_needed_o = !split_q_i && (be_second != '0);

  // Odd halfwords and unaligned words, whether split or not
  assign misaligned_o = ((size_i == lsu_pkg::SIZE_WORD) && (addr[1:0] != 2'b00)) ||
                        ((size_i == lsu_pkg::SIZE_HALF) && addr[0]);

  ////////////////////
  // Write data
  ////////////////////

  // Rotate left by offset, same word serves both phases
  always_comb begin
    case (addr[1:0])
      2'b00: data_wdata_o = wdata_i;
      2'b01: data_wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'b10: data_wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      2'b11: data_wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
      default: data_wdata_o = wdata_i;
    endcase
  end

  // Decode must never hand over a reserved size encoding
  always_comb begin
    if (!split_q_i && !$isunknown(size_i)) begin
      be_first_nonzero_a : assert final (data_be_o != '0)
        else $error("Zero byte enables in first phase");
    end
  end

endmodule

// File: logic/lsu_rdata_align.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_rdata_align (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ctrl_update_i,   // EX phase done, capture access info
  input  lsu_pkg::lsu_size_e   size_i,
  input  logic                 sext_i,
  input  logic                 we_i,
  input  lsu_pkg::lsu_offset_t offset_i,
  input  logic                 split_active_i,  // Current response is a first half
  input  logic                 resp_valid_i,
  input  lsu_pkg::lsu_word_t   resp_rdata_i,
  output lsu_pkg::lsu_word_t   rdata_o
);

  // Writeback side copy of the access
  lsu_pkg::lsu_size_e      size_q;
  logic                    sext_q;
  logic                    we_q;
  lsu_pkg::lsu_offset_t    offset_q;

  lsu_pkg::lsu_word_t      rdata_q;        // Low word of a split load
  logic                    rdata_is_split;
  logic [2*`LSU_DATA_W-1:0] rdata_full;    // Two word window
  lsu_pkg::lsu_word_t      rdata_win;      // Window after realignment

  ////////////////////
  // Access info
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      size_q   <= lsu_pkg::SIZE_BYTE;
      sext_q   <= 1'b0;
      we_q     <= 1'b0;
      offset_q <= '0;
    end else if (ctrl_update_i) begin
      // Both phases of a split write the same values
      size_q   <= size_i;
      sext_q   <= sext_i;
      we_q     <= we_i;
      offset_q <= offset_i;
    end
  end

  // Raw first half, used only on the following response
  always_ff @(posedge clk) begin
    if (resp_valid_i && !we_q && split_active_i) begin
      rdata_q <= resp_rdata_i;
    end
  end

  ////////////////////
  // Realignment
  ////////////////////

  assign rdata_is_split = ((size_q == lsu_pkg::SIZE_WORD) && (offset_q != 2'b00)) ||
                          ((size_q == lsu_pkg::SIZE_HALF) && (offset_q == 2'b11));

  // Split puts the held word below, otherwise the word is doubled so
  // that its low bytes wrap into the top after the shift
  assign rdata_full = rdata_is_split ? {resp_rdata_i, rdata_q}
                                     : {resp_rdata_i, resp_rdata_i};

  assign rdata_win = lsu_pkg::lsu_word_t'(rdata_full >> {offset_q, 3'b000});

  // Sign or zero extension by captured size
  always_comb begin
    case (size_q)
      lsu_pkg::SIZE_BYTE: rdata_o = {{24{sext_q && rdata_win[7]}},  rdata_win[7:0]};
      lsu_pkg::SIZE_HALF: rdata_o = {{16{sext_q && rdata_win[15]}}, rdata_win[15:0]};
      default:            rdata_o = rdata_win;                      // Full word
    endcase
  end

endmodule

// File: logic/lsu_ctrl.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_0_i,       // EX stage handshake
  input  logic ready_0_i,
  input  logic valid_1_i,       // WB stage handshake
  input  logic ready_1_i,
  input  logic split_needed_i,
  input  logic misaligned_i,
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  input  logic data_err_i,
  output logic data_req_o,
  output logic ready_0_o,
  output logic valid_0_o,
  output logic ready_1_o,
  output logic valid_1_o,
  output logic split_0_o,       // First phase of a split in EX
  output logic split_q_o,       // Second phase of a split in EX
  output logic split_active_o,  // Oldest outstanding transfer is a first half
  output logic ctrl_update_o,
  output logic err_1_o,
  output logic busy_o,
  output logic interruptible_o
);

  localparam lsu_pkg::lsu_cnt_t DEPTH = lsu_pkg::lsu_cnt_t'(`LSU_DEPTH);

  lsu_pkg::lsu_cnt_t cnt_q;      // Transfers granted but not answered
  lsu_pkg::lsu_cnt_t next_cnt;
  logic              count_up;   // Accepted request
  logic              count_down; // Response
  logic              done_0;     // Address phase finished
  logic              split_q;
  logic              last_resp;  // Response ends the access
  logic              err_q;      // Error seen on a first half
  logic              req_pend_q; // Request raised, not yet taken

  ////////////////////
  // Request and EX
  ////////////////////

  // New access only on an empty bus, the second half may overlap its first
  assign data_req_o = valid_0_i && (cnt_q < DEPTH) && ((cnt_q == '0) || split_q);

  assign count_up   = data_req_o && data_gnt_i;
  assign count_down = data_rvalid_i;

  assign split_0_o  = valid_0_i && split_needed_i;
  assign split_q_o  = split_q;

  // Nothing to do counts as done
  assign done_0        = (valid_0_i ? count_up : 1'b1) && ready_0_i;
  assign ctrl_update_o = done_0 && valid_0_i;
  assign ready_0_o     = done_0 && !split_0_o; // Hold EX through both phases
  assign valid_0_o     = count_up;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_0_i) begin
      split_q <= 1'b0;                         // Killed or idle, next starts clean
    end else if (ctrl_update_o) begin
      split_q <= split_0_o;                    // Set after phase one, clear after two
    end
  end

  ////////////////////
  // Outstanding count
  ////////////////////

  always_comb begin
    case ({count_up, count_down})
      2'b10:   next_cnt = cnt_q + 1'b1;
      2'b01:   next_cnt = cnt_q - 1'b1;
      default: next_cnt = cnt_q;               // Idle or both at once
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= next_cnt;
    end
  end

  ////////////////////
  // WB and status
  ////////////////////

  // Two in flight only happens for a split, so the head is its first half
  assign split_active_o = split_q || (cnt_q == DEPTH);
  assign last_resp      = data_rvalid_i && !split_active_o;

  assign ready_1_o = ((cnt_q == '0) || data_rvalid_i) && ready_1_i;
  assign valid_1_o = last_resp && valid_1_i;

  // Error of either half shows on the last response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else if (data_rvalid_i) begin
      err_q <= split_active_o && data_err_i;  // Cleared by the last half
    end
  end

  assign err_1_o = data_rvalid_i && (data_err_i || err_q);

  // A request held over a cycle must not be withdrawn
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_pend_q <= 1'b0;
    end else if (ctrl_update_o) begin
      req_pend_q <= 1'b0;
    end else if (data_req_o) begin
      req_pend_q <= 1'b1;
    end
  end

  assign busy_o          = (cnt_q != '0) || data_req_o;
  assign interruptible_o = !req_pend_q && (cnt_q == '0);

  ////////////////////
  // Checks
  ////////////////////

  cnt_max_a : assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= DEPTH);

  resp_pending_a : assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (cnt_q != '0));

  req_stable_a : assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && !data_gnt_i |=> data_req_o);

  // Operands must not change between the two phases
  split_misaligned_a : assert property (@(posedge clk) disable iff (!rst_n)
    valid_0_i && split_q |-> misaligned_i);

endmodule

// File: logic/lsu_top.sv
`timescale 1ns/100ps

module lsu_top (
  input  logic                clk,
  input  logic                rst_n,

  // EX stage
  input  logic                valid_0_i,
  output logic                ready_0_o,
  output logic                valid_0_o,
  input  logic                ready_0_i,
  input  lsu_pkg::lsu_word_t  operand_a_i,
  input  lsu_pkg::lsu_word_t  operand_b_i,
  input  lsu_pkg::lsu_word_t  wdata_i,
  input  logic                we_i,
  input  lsu_pkg::lsu_size_e  size_i,
  input  logic                sext_i,
  output logic                split_0_o,

  // WB stage
  input  logic                valid_1_i,
  output logic                ready_1_o,
  output logic                valid_1_o,
  input  logic                ready_1_i,
  output lsu_pkg::lsu_word_t  rdata_1_o,
  output logic                err_1_o,

  // Status
  output logic                busy_o,
  output logic                interruptible_o,

  // Data bus
  output logic                data_req_o,
  input  logic                data_gnt_i,
  output lsu_pkg::lsu_word_t  data_addr_o,
  output logic                data_we_o,
  output lsu_pkg::lsu_be_t    data_be_o,
  output lsu_pkg::lsu_word_t  data_wdata_o,
  input  logic                data_rvalid_i,
  input  lsu_pkg::lsu_word_t  data_rdata_i,
  input  logic                data_err_i
);

  logic                 split_q;
  logic                 split_needed;
  logic                 misaligned;
  logic                 split_active;
  logic                 ctrl_update;
  lsu_pkg::lsu_offset_t offset;

  ////////////////////
  // Request datapath
  ////////////////////

  lsu_req_align req_align_inst (
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .wdata_i        (wdata_i),
    .size_i         (size_i),
    .we_i           (we_i),
    .split_q_i      (split_q),
    .data_addr_o    (data_addr_o),
    .data_wdata_o   (data_wdata_o),
    .data_be_o      (data_be_o),
    .data_we_o      (data_we_o),
    .split_needed_o (split_needed),
    .misaligned_o   (misaligned),
    .offset_o       (offset)
  );

  lsu_ctrl ctrl_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .valid_0_i       (valid_0_i),
    .ready_0_i       (ready_0_i),
    .valid_1_i       (valid_1_i),
    .ready_1_i       (ready_1_i),
    .split_needed_i  (split_needed),
    .misaligned_i    (misaligned),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_err_i      (data_err_i),
    .data_req_o      (data_req_o),
    .ready_0_o       (ready_0_o),
    .valid_0_o       (valid_0_o),
    .ready_1_o       (ready_1_o),
    .valid_1_o       (valid_1_o),
    .split_0_o       (split_0_o),
    .split_q_o       (split_q),
    .split_active_o  (split_active),
    .ctrl_update_o   (ctrl_update),
    .err_1_o         (err_1_o),
    .busy_o          (busy_o),
    .interruptible_o (interruptible_o)
  );

  ////////////////////
  // Response datapath
  ////////////////////

  lsu_rdata_align rdata_align_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl_update_i  (ctrl_update),
    .size_i         (size_i),
    .sext_i         (sext_i),
    .we_i           (we_i),
    .offset_i       (offset),
    .split_active_i (split_active),
    .resp_valid_i   (data_rvalid_i),   // Bus response taken as is
    .resp_rdata_i   (data_rdata_i),
    .rdata_o        (rdata_1_o)
  );

endmodule

// File: tb/tb_data_mem.sv
`timescale 1ns/100ps

module tb_data_mem #(
  parameter logic [31:0] SEED = 32'h1
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o
);

  logic [7:0]  mem [256];    // Byte array, address wraps at 256
  integer      seed;
  logic [31:0] rdata_q [$];  // Responses waiting, oldest first
  logic        err_q [$];
  int          due_q [$];    // Cycle in which each response is driven
  int          cyc;
  int          last_due;
  int          base;
  int          delay;

  initial begin
    seed     = SEED;
    cyc      = 0;
    last_due = 0;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 8'(i * 73 + 19);  // Every address bit changes the byte
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
    end else begin
      cyc = cyc + 1;
      // Transfer taken, memory reads or writes right away
      if (req_i && gnt_o) begin
        base = {addr_i[7:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
          if (we_i && be_i[b]) mem[base + b] = wdata_i[8*b +: 8];
        end
        rdata_q.push_back({mem[base + 3], mem[base + 2], mem[base + 1], mem[base]});
        err_q.push_back(addr_i[7:4] == 4'hf);  // Top 16 bytes answer with error
        delay    = ($random(seed) & 32'h7fff) % 3;
        last_due = (cyc + delay > last_due) ? cyc + delay : last_due + 1; // Keep order
        due_q.push_back(last_due);
      end
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
      rdata_o  <= '0;
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        rvalid_o <= 1'b1;
        rdata_o  <= rdata_q.pop_front();
        err_o    <= err_q.pop_front();
        void'(due_q.pop_front());
      end
      gnt_o <= (($random(seed) & 3) != 0);  // Stall about one cycle in four
    end
  end

endmodule

// File: tb/tb_lsu.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module tb_lsu;

  localparam int          NUM_INSTR  = 300;
  localparam int          MAX_CYCLES = 40 * NUM_INSTR;  // Generous per instruction
  localparam logic [31:0] SEED_INIT  = 32'h8e97db9b;

  logic                 clk;
  logic                 rst_n;
  logic                 valid_0_i, ready_0_i, valid_1_i, ready_1_i;
  logic                 ready_0_o, valid_0_o, ready_1_o, valid_1_o;
  logic                 we_i, sext_i, split_0_o, err_1_o, busy_o, interruptible_o;
  lsu_pkg::lsu_word_t   operand_a_i, operand_b_i, wdata_i, rdata_1_o;
  lsu_pkg::lsu_size_e   size_i;
  logic                 data_req_o, data_gnt_i, data_we_o, data_rvalid_i, data_err_i;
  lsu_pkg::lsu_word_t   data_addr_o, data_wdata_o, data_rdata_i;
  lsu_pkg::lsu_be_t     data_be_o;

  integer               seed;
  logic [7:0]           model [256];   // Reference memory
  logic [31:0]          exp_rdata_q [$];
  logic                 exp_err_q [$];
  logic                 exp_load_q [$];
  logic                 last_q [$];    // Set where a granted transfer ends its access
  int                   error_count, cycle_count, issued, grant_cnt, cur_n;
  logic                 instr_active, prev_store, timed_out, all_done, last_flag;
  logic [31:0]          cur_addr, cur_wdata, exp_val;
  logic                 cur_we, cur_sext, cur_split, exp_err, exp_ready;
  lsu_pkg::lsu_size_e   cur_size;

  lsu_top lsu_top_inst (.*);

  tb_data_mem #(.SEED(SEED_INIT ^ 32'h5a5a_0001)) data_mem_inst (
    .clk(clk), .rst_n(rst_n), .req_i(data_req_o), .addr_i(data_addr_o),
    .we_i(data_we_o), .be_i(data_be_o), .wdata_i(data_wdata_o), .gnt_o(data_gnt_i),
    .rvalid_o(data_rvalid_i), .rdata_o(data_rdata_i), .err_o(data_err_i)
  );

  always #10 clk = ~clk;

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    error_count++;
  endtask

  task automatic report_fault(input string what);
    $display("Error: %s at %0t", what, $time);
    error_count++;
  endtask

  // Little endian bytes from the model with size extension
  function automatic logic [31:0] model_load(input logic [31:0] addr, input int n,
                                             input logic sext);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val[8*i +: 8] = model[(addr + i) & 255];
    end
    if (sext && val[8*n-1]) val = val | (32'hffff_ffff << (8 * n));
    return val;
  endfunction

  //////////////////////
  // Stimulus
  //////////////////////

  task automatic start_instr();
    logic [31:0] r;
    logic [31:0] op_a;
    logic [1:0]  sz;
    logic        reuse;
    logic        hit;
    r     = $random(seed);
    reuse = prev_store && r[0];  // Read back what was just stored
    if (!reuse) begin
      cur_addr = $random(seed) & 32'hff;
      sz       = r[7:1] % 3;
      cur_size = lsu_pkg::lsu_size_e'(sz);
    end
    cur_we    = !reuse && r[8];
    cur_sext  = r[9];
    cur_wdata = $random(seed);
    cur_n     = 1 << cur_size;
    cur_split = (int'(cur_addr[1:0]) + cur_n) > 4;  // Spills into the next word
    hit       = 1'b0;
    for (int i = 0; i < cur_n; i++) begin
      if (((cur_addr + i) & 255) >= 240) hit = 1'b1;
    end
    exp_err_q.push_back(hit);
    exp_load_q.push_back(!cur_we);
    exp_rdata_q.push_back(model_load(cur_addr, cur_n, cur_sext));
    op_a        = $random(seed);
    valid_0_i   <= 1'b1;
    operand_a_i <= op_a;
    operand_b_i <= cur_addr - op_a;  // Sum lands in the 256 byte range
    wdata_i     <= cur_wdata;
    we_i        <= cur_we;
    size_i      <= cur_size;
    sext_i      <= cur_sext;
    prev_store   = cur_we;
    instr_active = 1'b1;
    grant_cnt    = 0;
    issued++;
  endtask

  // Expected lanes per phase and the model update for stores
  task automatic check_transfer();
    logic [31:0] exp_addr;
    logic [31:0] exp_wdata;
    logic [3:0]  exp_be;
    int          off;
    int          pos;
    off      = cur_addr[1:0];
    exp_addr = (grant_cnt == 0) ? cur_addr : ((cur_addr & 32'hffff_fffc) + 32'd4);
    for (int l = 0; l < 4; l++) begin
      pos                 = grant_cnt * 4 + l - off;  // Access byte in this lane
      exp_be[l]           = (pos >= 0) && (pos < cur_n);
      exp_wdata[8*l +: 8] = cur_wdata[8*((l - off) & 3) +: 8];
      if (cur_we && exp_be[l]) model[((exp_addr & 32'hfc) + l) & 255] = exp_wdata[8*l +: 8];
    end
    if (data_addr_o !== exp_addr) report_value("data_addr_o", data_addr_o, exp_addr);
    if (data_be_o !== exp_be) report_value("data_be_o", data_be_o, exp_be);
    if (data_we_o !== cur_we) report_value("data_we_o", data_we_o, cur_we);
    if (cur_we && data_wdata_o !== exp_wdata) begin
      report_value("data_wdata_o", data_wdata_o, exp_wdata);
    end
    if (grant_cnt == 0 && split_0_o !== cur_split) begin
      report_value("split_0_o", split_0_o, cur_split);
    end
  endtask

  //////////////////////
  // Monitor and driver
  //////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) timed_out = 1'b1;
      // WB takes a result only on an idle bus or with a response in hand
      exp_ready = (last_q.size() == 0) || data_rvalid_i;
      if (ready_1_o !== exp_ready) report_value("ready_1_o", ready_1_o, exp_ready);
      if (data_rvalid_i) begin
        if (last_q.size() == 0) begin
          report_fault("bus response with no granted transfer");
        end else begin
          last_flag = last_q.pop_front();
          if (valid_1_o !== last_flag) report_value("valid_1_o", valid_1_o, last_flag);
          if (last_flag && exp_err_q.size() > 0) begin
            exp_err = exp_err_q.pop_front();
            exp_val = exp_rdata_q.pop_front();
            if (err_1_o !== exp_err) report_value("err_1_o", err_1_o, exp_err);
            if (exp_load_q.pop_front() && rdata_1_o !== exp_val) begin
              report_value("rdata_1_o", rdata_1_o, exp_val);
            end
          end
        end
      end else if (valid_1_o) begin
        report_fault("valid_1_o raised without a bus response");
      end
      if (data_req_o && data_gnt_i) begin
        if (!instr_active || grant_cnt > 1) begin
          report_fault("bus transfer outside an instruction");
        end else begin
          check_transfer();
          last_q.push_back(grant_cnt == 1 || !cur_split);
          grant_cnt++;
        end
      end
      if (last_q.size() > `LSU_DEPTH) report_fault("more than two transfers outstanding");
      if (instr_active && ready_0_o) begin
        if (grant_cnt != (cur_split ? 2 : 1)) begin
          report_value("grant count", grant_cnt, cur_split ? 2 : 1);
        end
        instr_active = 1'b0;
      end
      if (!instr_active) begin
        if (issued < NUM_INSTR) start_instr();
        else valid_0_i <= 1'b0;
      end
      all_done = (issued == NUM_INSTR) && !instr_active && (last_q.size() == 0);
    end
  end

  initial begin
    seed = SEED_INIT;
    clk = 1'b0;
    rst_n = 1'b0;
    valid_0_i = 1'b0;
    ready_0_i = 1'b1;
    valid_1_i = 1'b1;  // Writeback side always ready
    ready_1_i = 1'b1;
    operand_a_i = '0;
    operand_b_i = '0;
    wdata_i = '0;
    we_i = 1'b0;
    size_i = lsu_pkg::SIZE_BYTE;
    sext_i = 1'b0;
    {error_count, cycle_count, issued, grant_cnt} = '0;
    {instr_active, prev_store, timed_out, all_done} = '0;
    cur_size = lsu_pkg::SIZE_BYTE;
    for (int i = 0; i < 256; i++) begin
      model[i] = 8'(i * 73 + 19);  // Same fill as the bus responder
    end
    repeat (5) @(posedge clk);
    if (data_req_o !== 1'b0) report_value("data_req_o", data_req_o, 0);
    if (valid_0_o !== 1'b0) report_value("valid_0_o", valid_0_o, 0);
    if (valid_1_o !== 1'b0) report_value("valid_1_o", valid_1_o, 0);
    if (split_0_o !== 1'b0) report_value("split_0_o", split_0_o, 0);
    if (busy_o !== 1'b0) report_value("busy_o", busy_o, 0);
    if (interruptible_o !== 1'b1) report_value("interruptible_o", interruptible_o, 1);
    rst_n <= 1'b1;
    wait (all_done || timed_out);
    if (!all_done) report_fault("timeout before all instructions completed");
    $display("Errors: %0d, instructions: %0d, cycles: %0d", error_count, issued, cycle_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+include
logic/lsu_pkg.sv
logic/lsu_req_align.sv
logic/lsu_rdata_align.sv
logic/lsu_ctrl.sv
logic/lsu_top.sv
tb/tb_data_mem.sv
tb/tb_lsu.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - include
    files:
      - logic/lsu_pkg.sv
      - logic/lsu_req_align.sv
      - logic/lsu_rdata_align.sv
      - logic/lsu_ctrl.sv
      - logic/lsu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_data_mem.sv
      - tb/tb_lsu.sv
